// ==== hdl/apx_div_consts.svh ====
`ifndef APX_DIV_CONSTS_SVH
`define APX_DIV_CONSTS_SVH

// Operand and result width
`define APX_DIV_WIDTH 32

// Cap on the approximated low bits of the trial subtraction
`define APX_MAX_BITS 8

// One restoring iteration per quotient bit
`define DIV_STEPS 32

// Wishbone word addresses
`define REG_DIVIDEND  3'd0
`define REG_DIVISOR   3'd1
`define REG_CONTROL   3'd2
`define REG_QUOTIENT  3'd3
`define REG_REMAINDER 3'd4

`endif

// ==== hdl/apx_div_pkg.sv ====
`default_nettype none

`include "apx_div_consts.svh"

package apx_div_pkg;

    typedef logic [`APX_DIV_WIDTH-1:0] word_t;            // Operand or result

    typedef logic [7:0] er_t;                             // Error level from CONTROL

    typedef logic [2:0] wb_addr_t;                        // Bus word address

    typedef logic [$clog2(`DIV_STEPS)-1:0] step_t;        // Remaining iterations

    // Controller states
    typedef enum logic [1:0]
    {
        IDLE   = 2'd0,
        RUN    = 2'd1,
        FINISH = 2'd2
    } div_state_e;

endpackage

`default_nettype wire

// ==== hdl/div_job_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface div_job_if;

    logic                 start;      // One-cycle request from the register block
    apx_div_pkg::word_t   dividend;
    apx_div_pkg::word_t   divisor;
    apx_div_pkg::er_t     er;         // Raw error level, capped in the datapath
    logic                 busy;
    logic                 done;       // One-cycle pulse at the end of a job
    apx_div_pkg::word_t   quotient;
    apx_div_pkg::word_t   remainder;

    modport regs
    (
        output start, dividend, divisor, er,
        input  busy, done, quotient, remainder
    );

    modport ctrl
    (
        input  start,
        output busy, done
    );

    modport data
    (
        input  dividend, divisor, er,
        output quotient, remainder
    );

endinterface

`default_nettype wire

// ==== hdl/apx_lower_or_adder.sv ====
`timescale 1ns/1ps
`default_nettype none

module apx_lower_or_adder
#(
    parameter int WIDTH = 33
)
(
    input  wire [WIDTH-1:0]  a,
    input  wire [WIDTH-1:0]  b,
    input  wire              cin,
    input  wire [3:0]        k,
    output logic [WIDTH-1:0] sum,
    output logic             cout
);

    always_comb
    begin : add_chain
        logic c;
        c = (k == 4'd0) ? cin : 1'b0;               // cin only counts for the exact case
        for (int i = 0; i < WIDTH; i++)
        begin
            if (i < int'(k))
            begin
                sum[i] = a[i] | b[i];               // Approximate low part
                if (i == int'(k) - 1)
                    c = a[i] & b[i];                // Carry guess into the exact part
            end
            else
            begin
                sum[i] = a[i] ^ b[i] ^ c;
                c      = (a[i] & b[i]) | (c & (a[i] ^ b[i]));
            end
        end
        cout = c;
    end

endmodule

`default_nettype wire

// ==== hdl/div_step_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "apx_div_consts.svh"

module div_step_counter
(
    input  wire   CLK,
    input  wire   reset,
    input  wire   load,
    input  wire   step,
    output logic  last
);

    apx_div_pkg::step_t count;

    always_ff @(posedge CLK)
    begin
        if (reset)
            count <= '0;
        else if (load)
            count <= apx_div_pkg::step_t'(`DIV_STEPS - 1);    // Full job ahead
        else if (step)
            count <= count - 1'b1;
    end

    // Flags the final iteration while it is being taken
    assign last = step && (count == '0);

endmodule

`default_nettype wire

// ==== hdl/div_control_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module div_control_fsm
(
    input  wire       CLK,
    input  wire       reset,
    div_job_if.ctrl   job,
    input  wire       last,
    output logic      load,
    output logic      step
);

    apx_div_pkg::div_state_e state;
    apx_div_pkg::div_state_e state_next;

    always_ff @(posedge CLK)
    begin
        if (reset)
            state <= apx_div_pkg::IDLE;
        else
            state <= state_next;
    end

    always_comb
    begin
        state_next = state;
        load       = 1'b0;
        step       = 1'b0;
        job.done   = 1'b0;
        case (state)
            apx_div_pkg::IDLE:
            begin
                if (job.start)                      // Only accepted here
                begin
                    load       = 1'b1;
                    state_next = apx_div_pkg::RUN;
                end
            end
            apx_div_pkg::RUN:
            begin
                step = 1'b1;                        // One quotient bit per cycle
                if (last)
                    state_next = apx_div_pkg::FINISH;
            end
            apx_div_pkg::FINISH:
            begin
                job.done   = 1'b1;
                state_next = apx_div_pkg::IDLE;
            end
            default: state_next = apx_div_pkg::IDLE;
        endcase
    end

    assign job.busy = (state != apx_div_pkg::IDLE);

endmodule

`default_nettype wire

// ==== hdl/div_datapath.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "apx_div_consts.svh"

module div_datapath
(
    input  wire       CLK,
    input  wire       reset,
    div_job_if.data   job,
    input  wire       load,
    input  wire       step
);

    apx_div_pkg::word_t quo_r;          // Dividend shifting out, quotient shifting in
    apx_div_pkg::word_t rem_r;          // Partial remainder
    apx_div_pkg::word_t dvs_r;
    logic [3:0]         k_r;            // Approximated low bits
    logic [32:0]        shifted;
    logic [32:0]        trial;
    logic               keep;

    assign shifted = {rem_r, quo_r[31]};

    // Trial subtraction as shifted + ~divisor + 1
    apx_lower_or_adder #(
        .WIDTH (33)
    ) i_sub (
        .a    (shifted),
        .b    (~{1'b0, dvs_r}),
        .cin  (1'b1),
        .k    (k_r),
        .sum  (trial),
        .cout (keep)                    // No borrow means the trial fits
    );

    always_ff @(posedge CLK)
    begin
        if (reset)
        begin
            quo_r <= '0;
            rem_r <= '0;
            dvs_r <= '0;
            k_r   <= '0;
        end
        else if (load)
        begin
            quo_r <= job.dividend;
            rem_r <= '0;
            dvs_r <= job.divisor;
            if (job.er > `APX_MAX_BITS)
                k_r <= 4'(`APX_MAX_BITS);
            else
                k_r <= job.er[3:0];
        end
        else if (step)
        begin
            if (keep)
            begin
                rem_r <= trial[31:0];
                quo_r <= {quo_r[30:0], 1'b1};
            end
            else
            begin
                rem_r <= shifted[31:0]; // Restore
                quo_r <= {quo_r[30:0], 1'b0};
            end
        end
    end

    assign job.quotient  = quo_r;
    assign job.remainder = rem_r;

endmodule

`default_nettype wire

// ==== hdl/wb_div_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "apx_div_consts.svh"

module wb_div_regs
(
    input  wire                    CLK,
    input  wire                    reset,
    input  wire                    wb_cyc,
    input  wire                    wb_stb,
    input  wire                    wb_we,
    input  apx_div_pkg::wb_addr_t  wb_adr,
    input  apx_div_pkg::word_t     wb_dat_w,
    output apx_div_pkg::word_t     wb_dat_r,
    output logic                   wb_ack,
    div_job_if.regs                job
);

    apx_div_pkg::word_t dividend_r;
    apx_div_pkg::word_t divisor_r;
    apx_div_pkg::er_t   er_r;
    logic               start_r;
    logic               done_r;     // Sticky completion flag
    logic               access;
    logic               wr;
    logic               start_wr;

    assign access   = wb_cyc & wb_stb & ~wb_ack;              // New cycle, not yet acked
    assign wr       = access & wb_we;
    assign start_wr = wr && (wb_adr == `REG_CONTROL) && wb_dat_w[0];

    always_ff @(posedge CLK)
    begin
        if (reset)
        begin
            wb_ack     <= 1'b0;
            dividend_r <= '0;
            divisor_r  <= '0;
            er_r       <= '0;
            start_r    <= 1'b0;
            done_r     <= 1'b0;
        end
        else
        begin
            wb_ack  <= access;                                // Single-cycle ack
            start_r <= start_wr;                              // Pulse aligned with the ack
            if (wr)
            begin
                case (wb_adr)
                    `REG_DIVIDEND: dividend_r <= wb_dat_w;
                    `REG_DIVISOR:  divisor_r  <= wb_dat_w;
                    `REG_CONTROL:  er_r       <= wb_dat_w[15:8];
                    default:       ;                          // Results are read only
                endcase
            end
            if (start_wr)
                done_r <= 1'b0;
            else if (job.done)
                done_r <= 1'b1;
        end
    end

    assign job.start    = start_r;
    assign job.dividend = dividend_r;
    assign job.divisor  = divisor_r;
    assign job.er       = er_r;

    // Read-back mux, sampled by the master while wb_ack is high
    always_comb
    begin
        case (wb_adr)
            `REG_DIVIDEND:  wb_dat_r = dividend_r;
            `REG_DIVISOR:   wb_dat_r = divisor_r;
            `REG_CONTROL:   wb_dat_r = {16'd0, er_r, 6'd0, done_r, job.busy};
            `REG_QUOTIENT:  wb_dat_r = job.quotient;
            `REG_REMAINDER: wb_dat_r = job.remainder;
            default:        wb_dat_r = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/apx_divider_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module apx_divider_top
(
    input  wire                    CLK,
    input  wire                    reset,
    input  wire                    wb_cyc,
    input  wire                    wb_stb,
    input  wire                    wb_we,
    input  apx_div_pkg::wb_addr_t  wb_adr,
    input  apx_div_pkg::word_t     wb_dat_w,
    output apx_div_pkg::word_t     wb_dat_r,
    output logic                   wb_ack
);

    logic load;
    logic step;
    logic last;

    div_job_if job ();

    wb_div_regs i_regs (
        .CLK      (CLK),
        .reset    (reset),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .job      (job.regs)
    );

    div_control_fsm i_ctrl (
        .CLK   (CLK),
        .reset (reset),
        .job   (job.ctrl),
        .last  (last),
        .load  (load),
        .step  (step)
    );

    div_step_counter i_cnt (
        .CLK   (CLK),
        .reset (reset),
        .load  (load),
        .step  (step),
        .last  (last)
    );

    div_datapath i_data (
        .CLK   (CLK),
        .reset (reset),
        .job   (job.data),
        .load  (load),
        .step  (step)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen
#(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 16
)
(
    output logic CLK,
    output logic reset
);

    initial
    begin
        CLK = 1'b0;
        forever #(PERIOD_NS / 2) CLK = ~CLK;
    end

    // Release lines up with the stimulus phase
    initial
    begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge CLK);
        #1;
        reset = 1'b0;
    end

endmodule

`default_nettype wire

// ==== testbench/tb_apx_divider.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "apx_div_consts.svh"

module tb_apx_divider;

    localparam int    NUM_JOBS       = 200 + 200 + 2 * 20 + 1 + 2;
    localparam int    CYCLES_PER_JOB = 50;
    localparam int    CLK_PERIOD_NS  = 40;
    localparam longint TIMEOUT_NS    = longint'(NUM_JOBS) * CYCLES_PER_JOB * CLK_PERIOD_NS * 2;

    logic                   CLK;
    logic                   reset;
    logic                   wb_cyc;
    logic                   wb_stb;
    logic                   wb_we;
    apx_div_pkg::wb_addr_t  wb_adr;
    apx_div_pkg::word_t     wb_dat_w;
    apx_div_pkg::word_t     wb_dat_r;
    logic                   wb_ack;

    tb_clock_gen #(
        .PERIOD_NS    (CLK_PERIOD_NS),
        .RESET_CYCLES (16)
    ) i_clk (
        .CLK   (CLK),
        .reset (reset)
    );

    apx_divider_top i_dut (
        .CLK      (CLK),
        .reset    (reset),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack)
    );

    task automatic check_value(input string name, input apx_div_pkg::word_t expected,
                               input apx_div_pkg::word_t actual);
        if (actual !== expected)
        begin
            $display("error: %s expected 0x%08h actual 0x%08h", name, expected, actual);
            $display("Simulation finished: FAIL");
            $fatal(1, "Mismatch in %s", name);
        end
    endtask

    // Entered and left 1 ns after a rising edge
    task automatic bus_write(input apx_div_pkg::wb_addr_t adr, input apx_div_pkg::word_t data);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_adr   = adr;
        wb_dat_w = data;
        do
        begin
            @(posedge CLK);
            #1;
        end
        while (!wb_ack);
        wb_cyc = 1'b0;                                  // Ends the cycle before the next edge
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic bus_read(input apx_div_pkg::wb_addr_t adr, output apx_div_pkg::word_t data);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = adr;
        do
        begin
            @(posedge CLK);
            #1;
        end
        while (!wb_ack);
        data   = wb_dat_r;                              // Valid while ack is high
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
    endtask

    // Carry out in bit 33 above the 33-bit sum
    // Low k bits as a OR b with the carry guess a AND b taken at bit k-1
    function automatic logic [33:0] approx_add(input logic [32:0] a, input logic [32:0] b,
                                               input logic cin, input int k);
        logic [32:0] mask;
        logic [32:0] low;
        logic [33:0] upper;
        if (k == 0)
            return {1'b0, a} + {1'b0, b} + 34'(cin);
        mask  = (33'd1 << k) - 33'd1;
        low   = (a | b) & mask;
        upper = 34'(a >> k) + 34'(b >> k) + 34'(a[k-1] & b[k-1]);
        return (upper << k) | {1'b0, low};
    endfunction

    function automatic void reference_divide(input apx_div_pkg::word_t dvd,
                                             input apx_div_pkg::word_t dvs,
                                             input apx_div_pkg::er_t er,
                                             output apx_div_pkg::word_t q,
                                             output apx_div_pkg::word_t r);
        int          k;
        logic [32:0] shifted;
        logic [33:0] res;
        k = (er > `APX_MAX_BITS) ? `APX_MAX_BITS : int'(er);
        q = dvd;
        r = '0;
        for (int i = 0; i < `DIV_STEPS; i++)
        begin
            shifted = {r, q[31]};
            res     = approx_add(shifted, ~{1'b0, dvs}, 1'b1, k);
            if (res[33])                                // No borrow so the trial is kept
            begin
                r = res[31:0];
                q = {q[30:0], 1'b1};
            end
            else
            begin
                r = shifted[31:0];
                q = {q[30:0], 1'b0};
            end
        end
    endfunction

    // Spread divisor sizes so quotients vary in length
    function automatic apx_div_pkg::word_t random_divisor();
        apx_div_pkg::word_t d;
        d = $urandom >> ($urandom % 32);
        if (d == '0)
            d = 32'd1;
        return d;
    endfunction

    task automatic wait_done(input apx_div_pkg::er_t er);
        apx_div_pkg::word_t status;
        do
            bus_read(`REG_CONTROL, status);
        while (status[0] || !status[1]);                // Busy low with done high
        check_value("status after job", {16'd0, er, 8'h02}, status);
    endtask

    task automatic run_job(input apx_div_pkg::word_t dvd, input apx_div_pkg::word_t dvs,
                           input apx_div_pkg::er_t er,
                           output apx_div_pkg::word_t q, output apx_div_pkg::word_t r);
        bus_write(`REG_DIVIDEND, dvd);
        bus_write(`REG_DIVISOR, dvs);
        bus_write(`REG_CONTROL, {16'd0, er, 8'h01});
        wait_done(er);
        bus_read(`REG_QUOTIENT, q);
        bus_read(`REG_REMAINDER, r);
    endtask

    initial
    begin
        #(TIMEOUT_NS);
        $display("Timeout: the jobs did not complete within %0d ns", TIMEOUT_NS);
        $display("Simulation finished: FAIL");
        $fatal(1, "Watchdog expired");
    end

    initial
    begin
        apx_div_pkg::word_t dvd;
        apx_div_pkg::word_t dvs;
        apx_div_pkg::word_t new_dvd;
        apx_div_pkg::word_t new_dvs;
        apx_div_pkg::word_t q;
        apx_div_pkg::word_t r;
        apx_div_pkg::word_t exp_q;
        apx_div_pkg::word_t exp_r;
        apx_div_pkg::word_t rd;
        apx_div_pkg::er_t   er;
        apx_div_pkg::er_t   new_er;
        void'($urandom(35200));
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        @(negedge reset);
        @(posedge CLK);
        #1;

        bus_read(`REG_CONTROL, rd);
        check_value("reset control", 32'd0, rd);
        bus_read(`REG_QUOTIENT, rd);
        check_value("reset quotient", 32'd0, rd);
        bus_read(`REG_REMAINDER, rd);
        check_value("reset remainder", 32'd0, rd);

        repeat (200)
        begin
            dvd = $urandom;
            dvs = random_divisor();
            run_job(dvd, dvs, 8'd0, q, r);
            check_value("exact quotient", dvd / dvs, q);
            check_value("exact remainder", dvd % dvs, r);
        end

        repeat (200)
        begin
            dvd = $urandom;
            dvs = random_divisor();
            er  = 8'(1 + $urandom % 8);
            run_job(dvd, dvs, er, q, r);
            reference_divide(dvd, dvs, er, exp_q, exp_r);
            check_value("approx quotient", exp_q, q);
            check_value("approx remainder", exp_r, r);
        end

        // Levels above the cap behave as level 8
        repeat (20)
        begin
            dvd = $urandom;
            dvs = random_divisor();
            er  = 8'(9 + $urandom % 247);
            reference_divide(dvd, dvs, 8'd8, exp_q, exp_r);
            run_job(dvd, dvs, er, q, r);
            check_value("capped quotient", exp_q, q);
            check_value("capped remainder", exp_r, r);
            run_job(dvd, dvs, 8'd8, q, r);
            check_value("level 8 quotient", exp_q, q);
            check_value("level 8 remainder", exp_r, r);
        end

        dvd = $urandom;
        run_job(dvd, 32'd0, 8'd0, q, r);
        check_value("divide by zero quotient", 32'hFFFF_FFFF, q);
        check_value("divide by zero remainder", dvd, r);

        // New operands and a second start while the first job runs
        dvd     = $urandom;
        dvs     = random_divisor();
        er      = 8'($urandom % 9);
        new_dvd = $urandom;
        new_dvs = random_divisor();
        new_er  = 8'($urandom % 9);
        bus_write(`REG_DIVIDEND, dvd);
        bus_write(`REG_DIVISOR, dvs);
        bus_write(`REG_CONTROL, {16'd0, er, 8'h01});
        bus_write(`REG_DIVIDEND, new_dvd);
        bus_write(`REG_DIVISOR, new_dvs);
        bus_write(`REG_CONTROL, {16'd0, new_er, 8'h01});
        bus_read(`REG_CONTROL, rd);
        check_value("status while busy", {16'd0, new_er, 8'h01}, rd);
        wait_done(new_er);
        bus_read(`REG_QUOTIENT, q);
        bus_read(`REG_REMAINDER, r);
        reference_divide(dvd, dvs, er, exp_q, exp_r);
        check_value("busy start quotient", exp_q, q);
        check_value("busy start remainder", exp_r, r);
        bus_read(`REG_DIVIDEND, rd);
        check_value("new dividend readback", new_dvd, rd);
        bus_read(`REG_DIVISOR, rd);
        check_value("new divisor readback", new_dvs, rd);
        repeat (40) @(posedge CLK);
        #1;
        bus_read(`REG_CONTROL, rd);
        check_value("no second job started", {16'd0, new_er, 8'h02}, rd);

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== apx_divider_top.f ====
+incdir+hdl
hdl/apx_div_pkg.sv
hdl/div_job_if.sv
hdl/apx_lower_or_adder.sv
hdl/div_step_counter.sv
hdl/div_control_fsm.sv
hdl/div_datapath.sv
hdl/wb_div_regs.sv
hdl/apx_divider_top.sv
testbench/tb_clock_gen.sv
testbench/tb_apx_divider.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile and run the approximate divider testbench with Verilator
set -e

cd "$(dirname "$0")"

TOP=tb_apx_divider
LOG=sim.log

verilator --binary --timing -Wno-fatal \
    --top-module "$TOP" \
    -f apx_divider_top.f \
    -o "$TOP"

./obj_dir/"$TOP" | tee "$LOG"

if grep -q "Simulation finished: FAIL" "$LOG"; then
    echo "Simulation failed, see $LOG"
    exit 1
fi

if ! grep -q "Simulation finished: PASS" "$LOG"; then
    echo "Simulation ended without a result, see $LOG"
    exit 1
fi

echo "Simulation passed"
